/* src/hazardPkg.sv */
/*
 * Hazard control package
 * Field widths, the stage count, the decoded instruction class and
 * the exception-level operation shared by the hazard and stall logic
 */

package hazardPkg;

    // Five-stage core, F D E M W
    parameter int numStages = 5;
    // Records kept for the stages after D
    parameter int trackDepth = numStages - 2;

    // Register file address
    parameter int regAddrW = 5;
    // Tuse / Tnew, 0..3 cycles
    parameter int tW = 2;
    // External interrupt lines
    parameter int intW = 6;
    // MDU latency counter, up to 31 cycles
    parameter int mdCntW = 5;

    // Instruction class of the instruction in D
    typedef enum logic [2:0] {
        icAlu,
        icLoad,
        icStore,
        icBranch,
        icMul,
        icDiv,
        icMdMove,
        icEret
    } instrClassE;

    // Change of exception level requested this cycle
    typedef enum logic [1:0] {
        exlNone,
        exlEnter,
        exlLeave
    } exlOpE;

    // True for anything that touches the multiply/divide unit
    function automatic logic mdClass(input instrClassE cls);
        return (cls == icMul) || (cls == icDiv) || (cls == icMdMove);
    endfunction

endpackage

/* src/stageTracker.sv */
/*
 * Stage tracker
 * Keeps the pending register write of E, M and W: write enable,
 * destination and remaining Tnew. Records age by one as they move on,
 * stalled stages hold, cleared stages load a bubble
 */

`timescale 1ns/1ps

module stageTracker import hazardPkg::*; (
    input  logic                clk,
    input  logic                rst,
    // Record leaving D
    input  logic                regWEnD,
    input  logic [regAddrW-1:0] regWAddrD,
    input  logic [tW-1:0]       tnewD,
    // Per-stage control from the pipeline controller
    input  logic                stallE,
    input  logic                stallM,
    input  logic                stallW,
    input  logic                clearE,
    input  logic                clearM,
    input  logic                clearW,
    // Tracked records
    output logic                regWEnE,
    output logic [regAddrW-1:0] regWAddrE,
    output logic [tW-1:0]       tnewE,
    output logic                regWEnM,
    output logic [regAddrW-1:0] regWAddrM,
    output logic [tW-1:0]       tnewM,
    output logic                regWEnW,
    output logic [regAddrW-1:0] regWAddrW,
    output logic [tW-1:0]       tnewW
);

    // Index 0 is E, 1 is M, 2 is W
    logic [trackDepth-1:0] stallQ;
    logic [trackDepth-1:0] clearQ;
    logic [trackDepth-1:0] wEnQ;
    logic [regAddrW-1:0]   wAddrQ [trackDepth];
    logic [tW-1:0]         tNewQ  [trackDepth];

    // Record offered to each stage at the next edge
    logic [trackDepth-1:0] wEnIn;
    logic [regAddrW-1:0]   wAddrIn [trackDepth];
    logic [tW-1:0]         tNewIn  [trackDepth];

    assign stallQ = {stallW, stallM, stallE};
    assign clearQ = {clearW, clearM, clearE};

    always_comb begin
        // D record enters E unchanged
        wEnIn[0]   = regWEnD;
        wAddrIn[0] = regWAddrD;
        tNewIn[0]  = tnewD;
        // Later stages take the previous one, one cycle closer to ready
        for (int i = 1; i < trackDepth; i++) begin
            wEnIn[i]   = wEnQ[i-1];
            wAddrIn[i] = wAddrQ[i-1];
            tNewIn[i]  = (tNewQ[i-1] != '0) ? tNewQ[i-1] - 1'b1 : '0;
        end
    end

    // Write enable is the valid bit of a record
    always_ff @(posedge clk) begin
        for (int i = 0; i < trackDepth; i++) begin
            if (rst || clearQ[i]) begin
                wEnQ[i] <= 1'b0;
            end else if (!stallQ[i]) begin
                wEnQ[i] <= wEnIn[i];
            end
        end
    end

    // Payload only matters while the enable is set
    always_ff @(posedge clk) begin
        for (int i = 0; i < trackDepth; i++) begin
            if (!stallQ[i]) begin
                wAddrQ[i] <= wAddrIn[i];
                tNewQ[i]  <= tNewIn[i];
            end
        end
    end

    assign regWEnE   = wEnQ[0];
    assign regWAddrE = wAddrQ[0];
    assign tnewE     = tNewQ[0];
    assign regWEnM   = wEnQ[1];
    assign regWAddrM = wAddrQ[1];
    assign tnewM     = tNewQ[1];
    assign regWEnW   = wEnQ[2];
    assign regWAddrW = wAddrQ[2];
    assign tnewW     = tNewQ[2];

    // A flushed stage must not show up as a writer to the hazard check
    for (genvar g = 0; g < trackDepth; g++) begin : gClearChk
        assert property (@(posedge clk) disable iff (rst) clearQ[g] |=> !wEnQ[g])
            else $error("stage %0d reports a write after clear", g);
    end

endmodule

/* src/hazardDetect.sv */
/*
 * Hazard detector
 * Compares the D-stage sources and their Tuse against the writes
 * pending in E and M, and flags an MDU access while the MDU is busy
 */

`timescale 1ns/1ps

module hazardDetect import hazardPkg::*; (
    // Instruction in D
    input  instrClassE          classD,
    input  logic                useRsD,
    input  logic                useRtD,
    input  logic [regAddrW-1:0] addrRsD,
    input  logic [regAddrW-1:0] addrRtD,
    input  logic [tW-1:0]       tuseRsD,
    input  logic [tW-1:0]       tuseRtD,
    // Pending writes
    input  logic                regWEnE,
    input  logic [regAddrW-1:0] regWAddrE,
    input  logic [tW-1:0]       tnewE,
    input  logic                regWEnM,
    input  logic [regAddrW-1:0] regWAddrM,
    input  logic [tW-1:0]       tnewM,
    // MDU state
    input  logic                busyMd,
    output logic                waitReg,
    output logic                waitMd
);

    logic waitRs;
    logic waitRt;

    // One source against E and M; the value is late if Tnew exceeds Tuse
    function automatic logic srcWait(
        input logic                srcUsed,
        input logic [regAddrW-1:0] addr,
        input logic [tW-1:0]       tuse
    );
        logic hitE;
        logic hitM;
        hitE = regWEnE && (regWAddrE == addr) && (tnewE > tuse);
        hitM = regWEnM && (regWAddrM == addr) && (tnewM > tuse);
        // $0 is hardwired, never a dependency
        return srcUsed && (addr != '0) && (hitE || hitM);
    endfunction

    always_comb begin
        waitRs  = srcWait(useRsD, addrRsD, tuseRsD);
        waitRt  = srcWait(useRtD, addrRtD, tuseRtD);
        waitReg = waitRs || waitRt;
        // Any MDU instruction waits for the previous operation
        waitMd  = busyMd && mdClass(classD);
    end

endmodule

/* src/pipelineControl.sv */
/*
 * Pipeline controller
 * Fixed-priority encoder from exception-level change, data-side busy,
 * D-stage waits and fetch busy to the PC, MDU and D enables and the
 * per-stage stall and clear lines
 */

`timescale 1ns/1ps

module pipelineControl import hazardPkg::*; (
    input  logic  waitReg,
    input  logic  waitMd,
    input  logic  busyI,
    input  logic  busyD,
    input  exlOpE exlOp,
    output logic  enPc,
    output logic  enMd,
    output logic  enD,
    output logic  stallD,
    output logic  stallE,
    output logic  stallM,
    output logic  stallW,
    output logic  clearD,
    output logic  clearE,
    output logic  clearM,
    output logic  clearW
);

    // {enPc, enMd, enD, stall D E M W, clear D E M W}
    logic [10:0] ctrlVec;
    logic        exlChange;

    assign exlChange = (exlOp != exlNone);

    always_comb begin
        if (exlChange) begin
            // Redirect the PC, flush everything in flight
            ctrlVec = 11'b100_0000_1111;
        end else if (busyD) begin
            // Data side busy, freeze D through M, bubble into W
            ctrlVec = 11'b011_1110_0001;
        end else if (waitMd || waitReg || busyI) begin
            // Hold F/D, bubble into E
            ctrlVec = 11'b011_1000_0100;
        end else begin
            ctrlVec = 11'b111_0000_0000;
        end
    end

    assign {enPc, enMd, enD, stallD, stallE, stallM, stallW,
            clearD, clearE, clearM, clearW} = ctrlVec;

    // Stall and clear on one stage would contradict each other
    always_comb begin
        assert final (({stallD, stallE, stallM, stallW} &
                        {clearD, clearE, clearM, clearW}) == 4'b0000)
            else $error("stall and clear both set on one stage");
    end

endmodule

/* src/cp0Status.sv */
/*
 * CP0 status
 * Exception level bit and interrupt mask. Decides exception entry on a
 * request or an unmasked interrupt, and exit on eret in D
 */

`timescale 1ns/1ps

module cp0Status import hazardPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            excReq,
    input  logic [intW-1:0] intReq,
    // Mask write port
    input  logic            imWe,
    input  logic [intW-1:0] imData,
    input  instrClassE      classD,
    input  logic            enD,
    output exlOpE           exlOp,
    output logic            exlBit
);

    logic [intW-1:0] intMask;
    logic            enterReq;
    logic            leaveReq;

    // Entry only from normal level
    assign enterReq = !exlBit && (excReq || ((intReq & intMask) != '0));

    // Exit on eret while in exception level.
    // enD itself drops whenever an EXL op is active, so it cannot
    // qualify the request here; entry wins instead
    assign leaveReq = exlBit && (classD == icEret) && !enterReq;

    always_comb begin
        if (enterReq) begin
            exlOp = exlEnter;
        end else if (leaveReq) begin
            exlOp = exlLeave;
        end else begin
            exlOp = exlNone;
        end
    end

    // Level follows the op at the next edge
    always_ff @(posedge clk) begin
        if (rst) begin
            exlBit <= 1'b0;
        end else if (exlOp == exlEnter) begin
            exlBit <= 1'b1;
        end else if (exlOp == exlLeave) begin
            exlBit <= 1'b0;
        end
    end

    // All interrupts enabled out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            intMask <= '1;
        end else if (imWe) begin
            intMask <= imData;
        end
    end

    // Level only moves at the end of a cycle in which the controller flushed D
    assert property (@(posedge clk) disable iff (rst) $changed(exlBit) |-> $past(!enD))
        else $error("exception level changed without a pipeline flush");

endmodule

/* src/mduBusyTimer.sv */
/*
 * MDU busy timer
 * Models the iterative multiply/divide unit with a down-counter that
 * is loaded when a multiply or divide leaves D
 */

`timescale 1ns/1ps

module mduBusyTimer import hazardPkg::*; #(
    parameter int mulCycles = 5,
    parameter int divCycles = 10
) (
    input  logic       clk,
    input  logic       rst,
    input  instrClassE classD,
    input  logic       enMd,
    input  logic       stallD,
    output logic       busyMd
);

    logic [mdCntW-1:0] mdCnt;
    logic              mdStart;

    // Moves to/from HI/LO do not start an operation
    assign mdStart = mdClass(classD) && (classD != icMdMove) && enMd && !stallD;

    always_ff @(posedge clk) begin
        if (rst) begin
            mdCnt <= '0;
        end else if (mdStart) begin
            // Busy from the next cycle on, for the full latency
            mdCnt <= (classD == icDiv) ? mdCntW'(divCycles) : mdCntW'(mulCycles);
        end else if (mdCnt != '0) begin
            mdCnt <= mdCnt - 1'b1;
        end
    end

    assign busyMd = (mdCnt != '0);

endmodule

/* src/hazardTop.sv */
/*
 * Hazard and stall control top
 * Stage tracker, hazard detector, MDU timer, CP0 status and the
 * pipeline controller of a five-stage core, wired together
 */

`timescale 1ns/1ps

module hazardTop import hazardPkg::*; #(
    parameter int mulCycles = 5,
    parameter int divCycles = 10
) (
    input  logic                clk,
    input  logic                rst,
    // Decoded D fields
    input  instrClassE          classD,
    input  logic                useRsD,
    input  logic                useRtD,
    input  logic [regAddrW-1:0] addrRsD,
    input  logic [regAddrW-1:0] addrRtD,
    input  logic [tW-1:0]       tuseRsD,
    input  logic [tW-1:0]       tuseRtD,
    input  logic                regWEnD,
    input  logic [regAddrW-1:0] regWAddrD,
    input  logic [tW-1:0]       tnewD,
    // Cache busy levels
    input  logic                busyI,
    input  logic                busyD,
    // Exceptions and interrupts
    input  logic                excReq,
    input  logic [intW-1:0]     intReq,
    input  logic                imWe,
    input  logic [intW-1:0]     imData,
    output logic                enPc,
    output logic                enMd,
    output logic                enD,
    output logic                stallD,
    output logic                stallE,
    output logic                stallM,
    output logic                stallW,
    output logic                clearD,
    output logic                clearE,
    output logic                clearM,
    output logic                clearW,
    output logic                busyMd,
    output logic                exlBit
);

    // Tracker records seen by the hazard check
    logic                regWEnE;
    logic [regAddrW-1:0] regWAddrE;
    logic [tW-1:0]       tnewE;
    logic                regWEnM;
    logic [regAddrW-1:0] regWAddrM;
    logic [tW-1:0]       tnewM;
    // Conditions into the controller
    logic                waitReg;
    logic                waitMd;
    exlOpE               exlOp;

    // W record has no reader here
    stageTracker stageTracker_inst (
        .clk(clk), .rst(rst),
        .regWEnD(regWEnD), .regWAddrD(regWAddrD), .tnewD(tnewD),
        .stallE(stallE), .stallM(stallM), .stallW(stallW),
        .clearE(clearE), .clearM(clearM), .clearW(clearW),
        .regWEnE(regWEnE), .regWAddrE(regWAddrE), .tnewE(tnewE),
        .regWEnM(regWEnM), .regWAddrM(regWAddrM), .tnewM(tnewM),
        .regWEnW(), .regWAddrW(), .tnewW()
    );

    hazardDetect hazardDetect_inst (
        .classD(classD), .useRsD(useRsD), .useRtD(useRtD),
        .addrRsD(addrRsD), .addrRtD(addrRtD),
        .tuseRsD(tuseRsD), .tuseRtD(tuseRtD),
        .regWEnE(regWEnE), .regWAddrE(regWAddrE), .tnewE(tnewE),
        .regWEnM(regWEnM), .regWAddrM(regWAddrM), .tnewM(tnewM),
        .busyMd(busyMd), .waitReg(waitReg), .waitMd(waitMd)
    );

    mduBusyTimer #(
        .mulCycles(mulCycles),
        .divCycles(divCycles)
    ) mduBusyTimer_inst (
        .clk(clk), .rst(rst), .classD(classD),
        .enMd(enMd), .stallD(stallD), .busyMd(busyMd)
    );

    cp0Status cp0Status_inst (
        .clk(clk), .rst(rst), .excReq(excReq), .intReq(intReq),
        .imWe(imWe), .imData(imData), .classD(classD), .enD(enD),
        .exlOp(exlOp), .exlBit(exlBit)
    );

    pipelineControl pipelineControl_inst (
        .waitReg(waitReg), .waitMd(waitMd), .busyI(busyI), .busyD(busyD),
        .exlOp(exlOp), .enPc(enPc), .enMd(enMd), .enD(enD),
        .stallD(stallD), .stallE(stallE), .stallM(stallM), .stallW(stallW),
        .clearD(clearD), .clearE(clearE), .clearM(clearM), .clearW(clearW)
    );

endmodule

/* bench/hazardTop_tb.sv */
/*
 * Testbench for the hazard and stall control top
 * Applies a table of D-stage fields, busy levels, exception and
 * interrupt inputs, one row per cycle, and checks every control output
 */

`timescale 1ns/1ps

module hazardTop_tb import hazardPkg::*; ();

    localparam int mulCycles     = 5;
    localparam int divCycles     = 10;
    localparam int maxRows       = 64;
    localparam int timeoutCycles = 500;
    localparam int regFieldW     = 1 + regAddrW + tW;
    localparam int envW          = 4 + 2 * intW;

    // {enPc, enMd, enD, stall D E M W, clear D E M W} per priority level
    localparam logic [10:0] ctrlRun   = 11'b111_0000_0000;
    localparam logic [10:0] ctrlWaitD = 11'b011_1000_0100;
    localparam logic [10:0] ctrlBusyD = 11'b011_1110_0001;
    localparam logic [10:0] ctrlFlush = 11'b100_0000_1111;
    // Unused source or no write
    localparam logic [regFieldW-1:0] noReg = '0;
    localparam logic [envW-1:0]      quiet = '0;

    // Register fields are {use or write enable, address, Tuse or Tnew}
    // env is {busyI, busyD, excReq, intReq, imWe, imData}
    typedef struct packed {
        logic [3:0]           test;
        instrClassE           cls;
        logic [regFieldW-1:0] rs;
        logic [regFieldW-1:0] rt;
        logic [regFieldW-1:0] dst;
        logic [envW-1:0]      env;
        logic [10:0]          expCtrl;
        logic                 expMd;
        logic                 expExl;
    } rowT;

    logic                clk;
    logic                rst;
    instrClassE          classD;
    logic                useRsD, useRtD, regWEnD;
    logic [regAddrW-1:0] addrRsD, addrRtD, regWAddrD;
    logic [tW-1:0]       tuseRsD, tuseRtD, tnewD;
    logic                busyI, busyD, excReq, imWe;
    logic [intW-1:0]     intReq, imData;
    logic                enPc, enMd, enD, busyMd, exlBit;
    logic                stallD, stallE, stallM, stallW;
    logic                clearD, clearE, clearM, clearW;

    rowT rows [maxRows];
    int  nRows = 0;
    int  errors = 0;
    int  testErrors = 0;
    int  testsPassed = 0;
    int  testsFailed = 0;

    hazardTop #(
        .mulCycles(mulCycles),
        .divCycles(divCycles)
    ) hazardTop_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog for the whole table run
    initial begin
        for (int c = 0; c < timeoutCycles; c++) begin
            @(posedge clk);
        end
        $display("timeout, the row table did not complete within %0d cycles", timeoutCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [regFieldW-1:0] packReg(input int en, addr, t);
        return {1'(en), regAddrW'(addr), tW'(t)};
    endfunction

    function automatic logic [envW-1:0] packEnv(input int bI, bD, exc, intr, we, data);
        return {1'(bI), 1'(bD), 1'(exc), intW'(intr), 1'(we), intW'(data)};
    endfunction

    // Field order matches rowT
    task automatic addRow(input int test, input instrClassE cls,
                          input logic [regFieldW-1:0] rs, rt, dst,
                          input logic [envW-1:0] env, input logic [10:0] expCtrl,
                          input int expMd, expExl);
        rows[nRows] = {4'(test), cls, rs, rt, dst, env, expCtrl, 1'(expMd), 1'(expExl)};
        nRows++;
    endtask

    task automatic driveRow(input rowT r);
        classD <= r.cls;
        {useRsD, addrRsD, tuseRsD} <= r.rs;
        {useRtD, addrRtD, tuseRtD} <= r.rt;
        {regWEnD, regWAddrD, tnewD} <= r.dst;
        {busyI, busyD, excReq, intReq, imWe, imData} <= r.env;
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkRow(input rowT r);
        checkBit("enPc", enPc, r.expCtrl[10]);
        checkBit("enMd", enMd, r.expCtrl[9]);
        checkBit("enD", enD, r.expCtrl[8]);
        checkBit("stallD", stallD, r.expCtrl[7]);
        checkBit("stallE", stallE, r.expCtrl[6]);
        checkBit("stallM", stallM, r.expCtrl[5]);
        checkBit("stallW", stallW, r.expCtrl[4]);
        checkBit("clearD", clearD, r.expCtrl[3]);
        checkBit("clearE", clearE, r.expCtrl[2]);
        checkBit("clearM", clearM, r.expCtrl[1]);
        checkBit("clearW", clearW, r.expCtrl[0]);
        checkBit("busyMd", busyMd, r.expMd);
        checkBit("exlBit", exlBit, r.expExl);
    endtask

    task automatic reportTest(input logic [3:0] test);
        if (testErrors == 0) begin
            testsPassed++;
            $display("test %0d passed", test);
        end else begin
            testsFailed++;
            $display("test %0d failed with %0d mismatches", test, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic buildTable();
        // Test 1 checks idle inputs straight after reset
        addRow(1, icAlu, noReg, noReg, noReg, quiet, ctrlRun, 0, 0);
        // Test 2 has lw to $5 with Tnew 2, then addu reading $5 at Tuse 1
        addRow(2, icLoad, packReg(1, 1, 1), noReg, packReg(1, 5, 2), quiet, ctrlRun, 0, 0);
        addRow(2, icAlu, packReg(1, 5, 1), noReg, packReg(1, 6, 1), quiet, ctrlWaitD, 0, 0);
        addRow(2, icAlu, packReg(1, 5, 1), noReg, packReg(1, 6, 1), quiet, ctrlRun, 0, 0);
        // Pending write to $0 never holds a reader of $0
        addRow(2, icLoad, noReg, noReg, packReg(1, 0, 2), quiet, ctrlRun, 0, 0);
        addRow(2, icLoad, packReg(1, 0, 0), noReg, packReg(1, 7, 2), quiet, ctrlRun, 0, 0);
        // $7 pending in E but not marked used
        addRow(2, icAlu, packReg(0, 7, 0), packReg(0, 7, 0), noReg, quiet, ctrlRun, 0, 0);
        // Branch reads rt in D, $7 now in M with Tnew 1
        addRow(2, icBranch, noReg, packReg(1, 7, 0), noReg, quiet, ctrlWaitD, 0, 0);
        addRow(2, icBranch, noReg, packReg(1, 7, 0), noReg, quiet, ctrlRun, 0, 0);
        // Test 3 has mfhi behind mult, then behind div
        addRow(3, icMul, noReg, noReg, noReg, quiet, ctrlRun, 0, 0);
        repeat (mulCycles) begin
            addRow(3, icMdMove, noReg, noReg, noReg, quiet, ctrlWaitD, 1, 0);
        end
        addRow(3, icMdMove, noReg, noReg, noReg, quiet, ctrlRun, 0, 0);
        addRow(3, icDiv, noReg, noReg, noReg, quiet, ctrlRun, 0, 0);
        repeat (divCycles) begin
            addRow(3, icMdMove, noReg, noReg, noReg, quiet, ctrlWaitD, 1, 0);
        end
        addRow(3, icMdMove, noReg, noReg, noReg, quiet, ctrlRun, 0, 0);
        // Test 4 ranks busyD above busyI
        addRow(4, icAlu, noReg, noReg, noReg, packEnv(1, 1, 0, 0, 0, 0), ctrlBusyD, 0, 0);
        addRow(4, icAlu, noReg, noReg, noReg, packEnv(1, 0, 0, 0, 0, 0), ctrlWaitD, 0, 0);
        addRow(4, icAlu, noReg, noReg, noReg, quiet, ctrlRun, 0, 0);
        // Test 5 enters on excReq, ignores a second one, leaves on eret
        addRow(5, icAlu, noReg, noReg, noReg, packEnv(0, 0, 1, 0, 0, 0), ctrlFlush, 0, 0);
        addRow(5, icAlu, noReg, noReg, noReg, packEnv(0, 0, 1, 0, 0, 0), ctrlRun, 0, 1);
        addRow(5, icAlu, noReg, noReg, noReg, quiet, ctrlRun, 0, 1);
        addRow(5, icEret, noReg, noReg, noReg, quiet, ctrlFlush, 0, 1);
        addRow(5, icAlu, noReg, noReg, noReg, quiet, ctrlRun, 0, 0);
        // Test 6 masks line 0 off, then on again
        addRow(6, icAlu, noReg, noReg, noReg, packEnv(0, 0, 0, 0, 1, 'h3e), ctrlRun, 0, 0);
        addRow(6, icAlu, noReg, noReg, noReg, packEnv(0, 0, 0, 1, 0, 0), ctrlRun, 0, 0);
        addRow(6, icAlu, noReg, noReg, noReg, packEnv(0, 0, 0, 0, 1, 'h3f), ctrlRun, 0, 0);
        addRow(6, icAlu, noReg, noReg, noReg, packEnv(0, 0, 0, 1, 0, 0), ctrlFlush, 0, 0);
        addRow(6, icAlu, noReg, noReg, noReg, packEnv(0, 0, 0, 1, 0, 0), ctrlRun, 0, 1);
        addRow(6, icEret, noReg, noReg, noReg, quiet, ctrlFlush, 0, 1);
        addRow(6, icAlu, noReg, noReg, noReg, quiet, ctrlRun, 0, 0);
    endtask

    initial begin
        rst = 1'b1;
        driveRow('0);
        buildTable();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < nRows; i++) begin
            @(posedge clk);
            driveRow(rows[i]);
            // Control is combinational, settled by the falling edge
            @(negedge clk);
            checkRow(rows[i]);
            if (i == nRows - 1 || rows[i + 1].test != rows[i].test) begin
                reportTest(rows[i].test);
            end
        end
        $display("%0d tests passed, %0d tests failed, %0d mismatches over %0d rows",
                 testsPassed, testsFailed, errors, nRows);
        if (testsFailed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
src/hazardPkg.sv
src/stageTracker.sv
src/hazardDetect.sv
src/pipelineControl.sv
src/cp0Status.sv
src/mduBusyTimer.sv
src/hazardTop.sv
bench/hazardTop_tb.sv

/* Bender.yml */
package:
  name: hazard_control

sources:
  - files:
      - src/hazardPkg.sv
      - src/stageTracker.sv
      - src/hazardDetect.sv
      - src/pipelineControl.sv
      - src/cp0Status.sv
      - src/mduBusyTimer.sv
      - src/hazardTop.sv
  - target: simulation
    files:
      - bench/hazardTop_tb.sv
